// ==== Makefile ====
# Verilator build and run of the video dump testbench

VERILATOR ?= verilator
TOP       ?= tb_video_dump
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) vdump_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG) || { echo "run ended without a pass result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cpu_wr_decode.sv ====
// CPU write decoder, turns image writes into per-bank RAM and MMR strobes
// and holds the spare status byte
`timescale 1ns/1ps
`include "vdump_cfg.svh"

module cpu_wr_decode import vdump_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  dump_addr_t cpu_addr,
    input  byte_t      cpu_dout,
    input  logic       cpu_we,

    vram_bus_if.wr     wr [`VD_NBANKS],   // one per bank

    output byte_t      other              // spare byte
);

    logic       hit_ram;     // address in a RAM region
    logic       hit_other;   // address at or above 7020
    bank_idx_t  hit_bank;    // owning bank for RAM or MMR
    dump_addr_t loc_off;     // offset inside that region
    logic       hit_mmr;

    always_comb begin
        vd_decode(cpu_addr, hit_ram, hit_other, hit_bank, loc_off);
    end

    // what is neither RAM nor spare is one of the MMR files
    assign hit_mmr = ~hit_ram & ~hit_other;

    // strobes stay comb so the write lands on the same edge as cpu_we
    generate
        for (genvar i = 0; i < `VD_NBANKS; i++) begin : g_wr
            logic sel;   // this bank owns the address

            assign sel           = (hit_bank == bank_idx_t'(i));
            assign wr[i].ram_we  = cpu_we & hit_ram & sel;
            assign wr[i].mmr_we  = cpu_we & hit_mmr & sel;
            assign wr[i].wr_addr = loc_off;    // shared, bank slices low bits
            assign wr[i].wr_data = cpu_dout;
        end
    endgenerate

    // spare byte, mirrored over the whole top of the map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            other <= '0;
        end else if (cpu_we && hit_other) begin
            other <= cpu_dout;
        end
    end

endmodule

// ==== list.f ====
+incdir+.
vdump_pkg.sv
vram_bus_if.sv
cpu_wr_decode.sv
video_bank.sv
vram_dump.sv
video_dump_top.sv
tb_video_dump_props.sv
tb_video_dump.sv

// ==== tb_video_dump.sv ====
// video dump testbench with clock, reset, stimulus table,
// image reference model, compare task, timeout and summary
`timescale 1ns/1ps
`include "vdump_cfg.svh"

module tb_video_dump import vdump_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int STREAM_LEN   = 64;     // back-to-back dump addresses
    localparam int N_TESTS      = 6;

    localparam logic [1:0] OP_WR = 2'd0;  // CPU write
    localparam logic [1:0] OP_RD = 2'd1;  // dump read
    localparam logic [1:0] OP_ST = 2'd2;  // status read

    localparam logic [2:0] T_RESET  = 3'd0;
    localparam logic [2:0] T_RAM    = 3'd1;
    localparam logic [2:0] T_MMR    = 3'd2;
    localparam logic [2:0] T_ST     = 3'd3;
    localparam logic [2:0] T_ISO    = 3'd4;
    localparam logic [2:0] T_STREAM = 3'd5;

    typedef struct packed {
        logic [1:0] op;
        dump_addr_t addr;   // image address or debug_bus value
        byte_t      data;   // write data or st_scr value
        byte_t      exp;
        logic [2:0] test;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       cpu_we;
    dump_addr_t cpu_addr;
    dump_addr_t ioctl_addr;
    byte_t      cpu_dout;
    byte_t      ioctl_din;
    byte_t      debug_bus;
    byte_t      st_scr;
    byte_t      st_dout;

    row_t       tbl [$];
    dump_addr_t known_q [$];      // RAM addresses with defined contents
    dump_addr_t offs_q [$];       // offsets written in all three banks
    dump_addr_t stream_addr [$];
    byte_t      stream_exp [$];
    byte_t      img [1 << 15];    // reference image
    byte_t      spare;
    int         checks [N_TESTS];
    int         errs [N_TESTS];
    int         cycles;
    int         cycle_limit;
    bit         built;
    integer     seed = 32'habed97f0;
    string      test_name [N_TESTS] = '{"reset", "ram readback", "mmr and spare",
                                       "status select", "bank isolation", "dump stream"};

    video_dump_top u_video_dump_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_we     (cpu_we),
        .ioctl_addr (ioctl_addr),
        .ioctl_din  (ioctl_din),
        .debug_bus  (debug_bus),
        .st_scr     (st_scr),
        .st_dout    (st_dout)
    );

    bind vram_dump tb_video_dump_props u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .debug_bus (debug_bus),
        .st_scr    (st_scr),
        .ioctl_din (ioctl_din),
        .st_dout   (st_dout)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // run limit armed once the table length is known
    initial begin
        cycles = 0;
        wait (built);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
        $display("Some tests failed");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #2;                       // drive and sample away from the edge
    endtask

    function automatic byte_t model_read(dump_addr_t a);
        if (a >= `VD_OTHER_ADDR) begin
            return spare;         // mirrored over the top of the map
        end
        return img[a];
    endfunction

    task automatic write_row(dump_addr_t a, byte_t d, logic [2:0] t);
        if (a >= `VD_OTHER_ADDR) begin
            spare = d;
        end else begin
            img[a] = d;
        end
        if (a < `VD_MMR_BASE) begin
            known_q.push_back(a);
        end
        tbl.push_back('{OP_WR, a, d, d, t});
    endtask

    task automatic dump_row(dump_addr_t a, logic [2:0] t);
        tbl.push_back('{OP_RD, a, 8'h00, model_read(a), t});
    endtask

    task automatic status_row(byte_t db, byte_t scr, logic [2:0] t);
        byte_t e;
        if (!db[5]) begin
            e = scr;
        end else if (db[4]) begin
            e = model_read(`VD_MMR_BASE + dump_addr_t'(db[3:0]));      // palette MMR
        end else begin
            e = model_read(`VD_OBJ_MMR_BASE + dump_addr_t'(db[2:0]));  // object MMR of 8 regs
        end
        tbl.push_back('{OP_ST, dump_addr_t'(db), scr, e, t});
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp, logic [2:0] t);
        checks[t]++;
        if (got !== exp) begin
            errs[t]++;
            $display("CHECK FAILED at %0t ns: %s got %02h expected %02h",
                     $time, name, got, exp);
        end
    endtask

    task automatic report_test(logic [2:0] t);
        $display("test %0d %-15s %4d checks %3d errors", t + 1, test_name[t], checks[t], errs[t]);
    endtask

    task automatic build_table();
        dump_addr_t rst_addr [8] = '{15'h7000, 15'h700F, 15'h7010, 15'h7017,
                                     15'h7018, 15'h701F, 15'h7020, 15'h7FFF};
        dump_addr_t off;
        dump_addr_t a;
        int         idx;
        for (int k = 0; k < (1 << 15); k++) begin
            img[k] = 8'h00;       // MMR regions come out of reset cleared
        end
        spare = 8'h00;
        for (int k = 0; k < 8; k++) begin
            dump_row(rst_addr[k], T_RESET);
        end
        for (int k = 0; k < 8; k++) begin
            off = dump_addr_t'($random(seed)) & 15'h0FFF;   // valid in every bank
            offs_q.push_back(off);
            write_row(`VD_SCR_BASE + off, byte_t'($random(seed)), T_RAM);
            write_row(`VD_PAL_BASE + off, byte_t'($random(seed)), T_RAM);
            write_row(`VD_OBJ_BASE + off, byte_t'($random(seed)), T_RAM);
        end
        write_row(15'h3FFF, byte_t'($random(seed)), T_RAM);  // top of scroll
        write_row(15'h2ABC, byte_t'($random(seed)), T_RAM);
        write_row(15'h6FFF, byte_t'($random(seed)), T_RAM);  // top of object
        for (int k = 0; k < known_q.size(); k++) begin
            dump_row(known_q[k], T_RAM);
        end
        for (int k = 0; k < 32; k++) begin
            write_row(`VD_MMR_BASE + dump_addr_t'(k), byte_t'($random(seed)), T_MMR);
        end
        write_row(`VD_OTHER_ADDR, byte_t'($random(seed)), T_MMR);
        for (int k = 0; k < 32; k++) begin
            dump_row(`VD_MMR_BASE + dump_addr_t'(k), T_MMR);
        end
        for (int k = 4; k < 8; k++) begin
            dump_row(rst_addr[k] | 15'h0ABC, T_MMR);   // spare mirrors
        end
        write_row(15'h7FFF, byte_t'($random(seed)), T_MMR); // any mirror loads it
        dump_row(`VD_OTHER_ADDR, T_MMR);
        for (int k = 0; k < 6; k++) begin
            status_row(byte_t'($random(seed)) & 8'hDF, byte_t'($random(seed)), T_ST);
            status_row(8'h30 | (byte_t'($random(seed)) & 8'h0F), byte_t'($random(seed)), T_ST);
            status_row(8'h20 | (byte_t'($random(seed)) & 8'h07), byte_t'($random(seed)), T_ST);
        end
        for (int k = 0; k < 4; k++) begin
            off = offs_q[k];
            write_row(`VD_PAL_BASE + off, byte_t'($random(seed)), T_ISO);
            dump_row(`VD_SCR_BASE + off, T_ISO);   // neighbours keep old bytes
            dump_row(`VD_OBJ_BASE + off, T_ISO);
            dump_row(`VD_PAL_BASE + off, T_ISO);
        end
        for (int k = 0; k < STREAM_LEN; k++) begin
            idx = ($random(seed) & 32'h7fffffff) % known_q.size();
            if (k % 4 == 3) begin
                a = `VD_MMR_BASE + dump_addr_t'(k & 31);
            end else if (k % 8 == 5) begin
                a = `VD_OTHER_ADDR + (dump_addr_t'($random(seed)) & 15'h0FDF);
            end else begin
                a = known_q[idx];
            end
            stream_addr.push_back(a);
            stream_exp.push_back(model_read(a));
        end
        cycle_limit = 2 * (RESET_CYCLES + 2 * tbl.size() + STREAM_LEN + 2);
        built = 1'b1;
    endtask

    task automatic apply_row(row_t row);
        case (row.op)
            OP_WR: begin
                cpu_addr = row.addr;
                cpu_dout = row.data;
                cpu_we   = 1'b1;
                step();                // lands on this edge
                cpu_we   = 1'b0;
            end
            OP_RD: begin
                ioctl_addr = row.addr;
                step();
                step();                // two-stage pipeline
                check_byte($sformatf("ioctl_din[%04h]", row.addr), ioctl_din, row.exp, row.test);
            end
            default: begin
                debug_bus = row.addr[7:0];
                st_scr    = row.data;
                step();
                check_byte($sformatf("st_dout[db=%02h]", row.addr[7:0]), st_dout, row.exp,
                           row.test);
            end
        endcase
    endtask

    initial begin
        int total_checks;
        int total_errs;
        int prop_fails;
        total_checks = 0;
        total_errs   = 0;
        rst_n        = 1'b0;
        cpu_we       = 1'b0;
        cpu_addr     = '0;
        cpu_dout     = '0;
        ioctl_addr   = `VD_MMR_BASE;   // keeps the pipeline on cleared MMRs
        debug_bus    = '0;
        st_scr       = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_byte("ioctl_din", ioctl_din, 8'h00, T_RESET);
        check_byte("st_dout", st_dout, 8'h00, T_RESET);
        for (int r = 0; r < tbl.size(); r++) begin
            apply_row(tbl[r]);
            if (r == tbl.size() - 1 || tbl[r + 1].test != tbl[r].test) begin
                report_test(tbl[r].test);
            end
        end
        // one address per cycle with the result due two cycles later
        for (int i = 0; i < STREAM_LEN + 2; i++) begin
            if (i >= 2) begin
                check_byte($sformatf("ioctl_din[%04h]", stream_addr[i - 2]), ioctl_din,
                           stream_exp[i - 2], T_STREAM);
            end
            if (i < STREAM_LEN) begin
                ioctl_addr = stream_addr[i];
            end
            step();
        end
        report_test(T_STREAM);
        for (int t = 0; t < N_TESTS; t++) begin
            total_checks += checks[t];
            total_errs   += errs[t];
        end
        prop_fails = u_video_dump_top.u_vram_dump.u_props.fail_cnt;
        if (prop_fails != 0) begin
            $display("bound assertions on the dump block failed %0d times", prop_fails);
        end
        total_errs += prop_fails;
        $display("summary: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tb_video_dump_props.sv ====
// bound checks on reset values and status timing of the dump block
`timescale 1ns/1ps

module tb_video_dump_props import vdump_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input byte_t debug_bus,
    input byte_t st_scr,
    input byte_t ioctl_din,
    input byte_t st_dout
);

    int fail_cnt = 0;    // failed assertion count

    // both outputs held clear in reset
    a_rst_ioctl: assert property (@(posedge clk) !rst_n |-> ioctl_din == 8'h00)
        else begin
            $error("ioctl_din not zero during reset");
            fail_cnt++;
        end

    a_rst_st: assert property (@(posedge clk) !rst_n |-> st_dout == 8'h00)
        else begin
            $error("st_dout not zero during reset");
            fail_cnt++;
        end

    // external scroll status is a single register stage
    a_st_pass: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(debug_bus[5])) |-> st_dout == $past(st_scr))
        else begin
            $error("st_dout does not follow st_scr one cycle later");
            fail_cnt++;
        end

endmodule

// ==== vdump_cfg.svh ====
// bank sizes, MMR file sizes and region base addresses
// of the compact dump image
`ifndef VDUMP_CFG_SVH
`define VDUMP_CFG_SVH

`define VD_NBANKS        3          // scroll, palette, object

// RAM address widths per bank
`define VD_SCR_AW        14         // 16 kB scroll tiles
`define VD_PAL_AW        12         // 4 kB palette
`define VD_OBJ_AW        13         // 8 kB objects

// MMR index widths per bank
`define VD_PAL_MMR_AW    4          // 16 regs
`define VD_SCR_MMR_AW    3          // 8 regs
`define VD_OBJ_MMR_AW    3          // 8 regs
`define VD_MMR_IW        4          // widest MMR index, shared bus width

// region starts in the 15-bit image
`define VD_SCR_BASE      15'h0000
`define VD_PAL_BASE      15'h4000
`define VD_OBJ_BASE      15'h5000
`define VD_MMR_BASE      15'h7000   // palette MMR first
`define VD_SCR_MMR_BASE  15'h7010
`define VD_OBJ_MMR_BASE  15'h7018
`define VD_OTHER_ADDR    15'h7020   // spare byte, repeats above here

`endif

// ==== vdump_pkg.sv ====
// shared types for the video dump path, plus the image address decoder
`include "vdump_cfg.svh"

package vdump_pkg;

    typedef logic [7:0]  byte_t;        // RAM, MMR and port data
    typedef logic [14:0] dump_addr_t;   // CPU and ioctl image address
    typedef logic [1:0]  bank_idx_t;    // bank number

    localparam bank_idx_t BK_SCR = 2'd0;
    localparam bank_idx_t BK_PAL = 2'd1;
    localparam bank_idx_t BK_OBJ = 2'd2;

    // splits an image address into region kind, bank and local offset
    // used by both the CPU write side and the dump side
    function automatic void vd_decode(
        input  dump_addr_t addr,
        output logic       is_ram,      // RAM region hit
        output logic       is_other,    // spare byte hit
        output bank_idx_t  bank,
        output dump_addr_t off          // bank-local offset
    );
        is_ram   = 1'b0;
        is_other = 1'b0;
        bank     = BK_SCR;
        off      = '0;
        if (addr < `VD_PAL_BASE) begin
            is_ram = 1'b1;
            off    = addr - `VD_SCR_BASE;
        end else if (addr < `VD_OBJ_BASE) begin
            is_ram = 1'b1;
            bank   = BK_PAL;
            off    = addr - `VD_PAL_BASE;
        end else if (addr < `VD_MMR_BASE) begin
            is_ram = 1'b1;
            bank   = BK_OBJ;
            off    = addr - `VD_OBJ_BASE;
        end else if (addr < `VD_SCR_MMR_BASE) begin
            bank = BK_PAL;                  // palette MMR 7000~700F
            off  = addr - `VD_MMR_BASE;
        end else if (addr < `VD_OBJ_MMR_BASE) begin
            off  = addr - `VD_SCR_MMR_BASE;  // scroll MMR 7010~7017
        end else if (addr < `VD_OTHER_ADDR) begin
            bank = BK_OBJ;                  // object MMR 7018~701F
            off  = addr - `VD_OBJ_MMR_BASE;
        end else begin
            is_other = 1'b1;                // everything from 7020 up
        end
    endfunction

endpackage

// ==== video_bank.sv ====
// one video bank: byte RAM with a registered read port
// plus a small MMR file with two comb read ports
`timescale 1ns/1ps

module video_bank import vdump_pkg::*; #(
    parameter int ram_aw = 12,   // RAM address bits
    parameter int mmr_aw = 3     // MMR index bits
) (
    input  logic       clk,
    input  logic       rst_n,

    vram_bus_if.bank_wr wr,      // CPU write side
    vram_bus_if.bank_rd rd       // dump and status side
);

    localparam int RAM_DEPTH = 1 << ram_aw;
    localparam int MMR_DEPTH = 1 << mmr_aw;

    byte_t mem [RAM_DEPTH];      // contents undefined after reset
    byte_t mmr [MMR_DEPTH];

    logic [ram_aw-1:0] ram_waddr;
    logic [ram_aw-1:0] ram_raddr;
    logic [mmr_aw-1:0] mmr_waddr;
    logic [mmr_aw-1:0] mmr_ridx;
    logic [mmr_aw-1:0] st_ridx;

    // local offsets, upper bits are always zero inside a region
    assign ram_waddr = wr.wr_addr[ram_aw-1:0];
    assign ram_raddr = rd.rd_addr[ram_aw-1:0];
    assign mmr_waddr = wr.wr_addr[mmr_aw-1:0];
    assign mmr_ridx  = rd.mmr_rd_idx[mmr_aw-1:0];
    assign st_ridx   = rd.st_idx[mmr_aw-1:0];

    // RAM write port
    always_ff @(posedge clk) begin
        if (wr.ram_we) begin
            mem[ram_waddr] <= wr.wr_data;
        end
    end

    // RAM read port, one cycle after rd_addr
    always_ff @(posedge clk) begin
        rd.rd_data <= mem[ram_raddr];
    end

    // MMR file, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < MMR_DEPTH; k++) begin
                mmr[k] <= '0;
            end
        end else if (wr.mmr_we) begin
            mmr[mmr_waddr] <= wr.wr_data;
        end
    end

    // two independent comb reads
    assign rd.mmr_rd_data = mmr[mmr_ridx];   // dump
    assign rd.st_data     = mmr[st_ridx];    // status

endmodule

// ==== video_dump_top.sv ====
// top level of the video dump path: CPU write decoder,
// three video banks and the ioctl dump block
`timescale 1ns/1ps
`include "vdump_cfg.svh"

module video_dump_top import vdump_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // CPU write port
    input  dump_addr_t cpu_addr,
    input  byte_t      cpu_dout,
    input  logic       cpu_we,

    // download port
    input  dump_addr_t ioctl_addr,
    output byte_t      ioctl_din,

    // status port
    input  byte_t      debug_bus,
    input  byte_t      st_scr,
    output byte_t      st_dout
);

    byte_t other;                     // spare byte, decoder to dump

    vram_bus_if vbus [`VD_NBANKS] (); // one bus per bank

    cpu_wr_decode u_cpu_wr_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_we   (cpu_we),
        .wr       (vbus),
        .other    (other)
    );

    // bank 0 scroll, 1 palette, 2 object
    generate
        for (genvar i = 0; i < `VD_NBANKS; i++) begin : g_bank
            video_bank #(
                .ram_aw (i == 0 ? `VD_SCR_AW :
                         i == 1 ? `VD_PAL_AW : `VD_OBJ_AW),
                .mmr_aw (i == 0 ? `VD_SCR_MMR_AW :
                         i == 1 ? `VD_PAL_MMR_AW : `VD_OBJ_MMR_AW)
            ) u_video_bank (
                .clk   (clk),
                .rst_n (rst_n),
                .wr    (vbus[i]),
                .rd    (vbus[i])
            );
        end
    endgenerate

    vram_dump u_vram_dump (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd         (vbus),
        .other      (other),
        .ioctl_addr (ioctl_addr),
        .ioctl_din  (ioctl_din),
        .debug_bus  (debug_bus),
        .st_scr     (st_scr),
        .st_dout    (st_dout)
    );

endmodule

// ==== vram_bus_if.sv ====
// per-bank bus between the CPU write decoder, one video bank
// and the dump block
`timescale 1ns/1ps
`include "vdump_cfg.svh"

interface vram_bus_if import vdump_pkg::*; ();

    // write side, from the CPU decoder
    logic                  ram_we;       // RAM byte write
    logic                  mmr_we;       // MMR byte write
    dump_addr_t            wr_addr;      // bank-local offset
    byte_t                 wr_data;

    // read side, dump and status
    dump_addr_t            rd_addr;      // bank-local RAM offset
    byte_t                 rd_data;      // registered RAM byte
    logic [`VD_MMR_IW-1:0] mmr_rd_idx;   // dump MMR index
    byte_t                 mmr_rd_data;  // comb
    logic [`VD_MMR_IW-1:0] st_idx;       // status MMR index
    byte_t                 st_data;      // comb

    modport wr (
        output ram_we, mmr_we, wr_addr, wr_data
    );

    modport bank_wr (
        input  ram_we, mmr_we, wr_addr, wr_data
    );

    modport rd (
        output rd_addr, mmr_rd_idx, st_idx,
        input  rd_data, mmr_rd_data, st_data
    );

    modport bank_rd (
        input  rd_addr, mmr_rd_idx, st_idx,
        output rd_data, mmr_rd_data, st_data
    );

endinterface

// ==== vram_dump.sv ====
// dump multiplexer for the ioctl image, two-stage pipeline over all regions
// plus the registered status byte selected by debug_bus
`timescale 1ns/1ps
`include "vdump_cfg.svh"

module vram_dump import vdump_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    vram_bus_if.rd     rd [`VD_NBANKS],   // bank read ports
    input  byte_t      other,             // spare byte from CPU side

    input  dump_addr_t ioctl_addr,
    output byte_t      ioctl_din,

    input  byte_t      debug_bus,
    input  byte_t      st_scr,            // external scroll status
    output byte_t      st_dout
);

    // comb decode of the dump address
    logic       dec_ram;
    logic       dec_other;
    bank_idx_t  dec_bank;
    dump_addr_t dec_off;

    // bank returns gathered into plain arrays for indexing
    byte_t ram_dout [`VD_NBANKS];
    byte_t mmr_dout [`VD_NBANKS];
    byte_t st_mmr   [`VD_NBANKS];

    // stage 1, lines up with the bank RAM read register
    logic      ram_q;      // region was RAM
    bank_idx_t bank_q;     // which bank
    byte_t     aux_q;      // MMR or spare byte carried along

    byte_t     aux_nxt;
    byte_t     dump_nxt;
    byte_t     st_nxt;

    always_comb begin
        vd_decode(ioctl_addr, dec_ram, dec_other, dec_bank, dec_off);
    end

    generate
        for (genvar i = 0; i < `VD_NBANKS; i++) begin : g_rd
            assign rd[i].rd_addr    = dec_off;                      // all banks, one used
            assign rd[i].mmr_rd_idx = dec_off[`VD_MMR_IW-1:0];
            assign rd[i].st_idx     = debug_bus[`VD_MMR_IW-1:0];    // bits 3:0
            assign ram_dout[i]      = rd[i].rd_data;
            assign mmr_dout[i]      = rd[i].mmr_rd_data;
            assign st_mmr[i]        = rd[i].st_data;
        end
    endgenerate

    // MMR reads are comb, so sample them now and delay to match RAM
    assign aux_nxt = dec_other ? other : mmr_dout[dec_bank];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_q  <= 1'b0;
            bank_q <= BK_SCR;
            aux_q  <= '0;
        end else begin
            ram_q  <= dec_ram;
            bank_q <= dec_bank;
            aux_q  <= aux_nxt;
        end
    end

    // stage 2 select, RAM byte is now valid at the bank output
    assign dump_nxt = ram_q ? ram_dout[bank_q] : aux_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ioctl_din <= '0;
        end else begin
            ioctl_din <= dump_nxt;   // two cycles after ioctl_addr
        end
    end

    // status: bit 5 picks MMR over st_scr, bit 4 picks palette over object
    always_comb begin
        if (!debug_bus[5]) begin
            st_nxt = st_scr;
        end else if (debug_bus[4]) begin
            st_nxt = st_mmr[BK_PAL];
        end else begin
            st_nxt = st_mmr[BK_OBJ];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_dout <= '0;
        end else begin
            st_dout <= st_nxt;       // one cycle
        end
    end

endmodule
